//--- common/ddram_pkg.sv
// ddram package
// shared widths, line geometry, client lane types and scheduler states
`default_nettype none

package ddram_pkg;

	localparam int DDR_AW     = 29;
	localparam int DDR_DW     = 64;
	localparam int DDR_BEW    = 8;
	localparam int CLIENT_AW  = 18;
	localparam int CLIENT_DW  = 16;
	localparam int CLIENT_BEW = CLIENT_DW / 8;
	localparam int LANES      = DDR_DW / CLIENT_DW;
	localparam int LANE_W     = 2;
	localparam int LINE_WORDS = 4;
	localparam int LINE_IDX_W = 2;
	localparam int TAG_W      = CLIENT_AW - LINE_IDX_W - LANE_W;
	localparam int BURST_W    = 8;

	typedef logic [DDR_AW-1:0]     ddr_addr_t;
	typedef logic [DDR_DW-1:0]     ddr_data_t;
	typedef logic [DDR_BEW-1:0]    ddr_be_t;
	typedef logic [CLIENT_AW-1:0]  client_addr_t;
	typedef logic [CLIENT_DW-1:0]  client_data_t;
	typedef logic [CLIENT_BEW-1:0] hw_be_t;
	typedef logic [LANE_W-1:0]     lane_t;
	typedef logic [LINE_IDX_W-1:0] line_idx_t;
	typedef logic [TAG_W-1:0]      line_tag_t;

	// one queued client write
	typedef struct packed {
		client_addr_t addr;
		client_data_t data;
		hw_be_t       be;
	} wr_entry_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} sched_state_t;

endpackage

`default_nettype wire

//--- common/client_if.sv
// client link between a client port and the DDR scheduler
// carries the write queue head, the refill request and the returning line beats
`timescale 1ns/1ns
`default_nettype none

interface client_if import ddram_pkg::*; ();

	logic      wr_valid;
	ddr_addr_t wr_addr;
	ddr_data_t wr_data;
	ddr_be_t   wr_be;
	logic      rd_miss;
	ddr_addr_t line_addr;

	logic      wr_pop;
	logic      fill_en;
	line_idx_t fill_idx;
	ddr_data_t fill_data;
	logic      fill_done;

	modport port (
		output wr_valid, wr_addr, wr_data, wr_be, rd_miss, line_addr,
		input  wr_pop, fill_en, fill_idx, fill_data, fill_done
	);

	modport sched (
		input  wr_valid, wr_addr, wr_data, wr_be, rd_miss, line_addr,
		output wr_pop, fill_en, fill_idx, fill_data, fill_done
	);

endinterface

`default_nettype wire

//--- client/write_fifo.sv
// posted write queue
// pointer pair plus occupancy count, head is shown without a read latency
`timescale 1ns/1ns
`default_nettype none

module write_fifo import ddram_pkg::*; #(
	parameter int DEPTH_LOG2 = 3
) (
	input  logic      clk,
	input  logic      rst_pulse,
	input  logic      push,
	input  wr_entry_t push_data,
	input  logic      pop,
	output wr_entry_t head,
	output logic      empty,
	output logic      full
);

	wr_entry_t             mem [2**DEPTH_LOG2];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0]   count;
	logic                  do_push;
	logic                  do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// count reaches 2**DEPTH_LOG2 only when every slot holds an entry
	assign empty = (count == '0);
	assign full  = count[DEPTH_LOG2];
	assign head  = mem[rd_ptr];

endmodule

`default_nettype wire

//--- client/line_cache.sv
// one-line read buffer
// refill beats are written on the clock, the client word is read combinationally
`timescale 1ns/1ns
`default_nettype none

module line_cache import ddram_pkg::*; (
	input  logic      clk,
	input  logic      wr_en,
	input  line_idx_t wr_idx,
	input  ddr_data_t wr_data,
	input  line_idx_t rd_idx,
	output ddr_data_t rd_data
);

	ddr_data_t mem [LINE_WORDS];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
	end

	assign rd_data = mem[rd_idx];

endmodule

`default_nettype wire

//--- client/client_port.sv
// client port
// one-line read cache with tag and dirty flag, posted write queue,
// write packing into 64-bit lanes and halfword select for read data
`timescale 1ns/1ns
`default_nettype none

module client_port import ddram_pkg::*; #(
	parameter ddr_addr_t REGION_BASE = '0,
	parameter int        FIFO_LOG2   = 3
) (
	input  logic         clk,
	input  logic         rst_pulse,
	input  client_addr_t addr,
	input  client_data_t din,
	input  logic         rd,
	input  hw_be_t       wr,
	output client_data_t dout,
	output logic         busy,
	client_if.port       bus
);

	wr_entry_t push_entry;
	wr_entry_t head;
	logic      fifo_empty;
	logic      fifo_full;
	logic      rd_ok;
	logic      wr_ok;
	logic      hit;
	line_tag_t addr_tag;
	line_tag_t line_tag;
	line_idx_t rd_word;
	lane_t     rd_lane;
	lane_t     wr_lane;
	logic      line_dirty;
	logic      hit_busy;
	logic      rd_miss;
	ddr_data_t line_word;

	assign busy  = fifo_full | hit_busy | rd_miss;
	assign rd_ok = rd && !busy;
	assign wr_ok = (|wr) && !busy;

	assign addr_tag   = addr[CLIENT_AW-1 -: TAG_W];
	assign hit        = !line_dirty && (addr_tag == line_tag);
	assign push_entry = '{addr: addr, data: din, be: wr};

	write_fifo #(
		.DEPTH_LOG2 (FIFO_LOG2)
	) i_write_fifo (
		.clk       (clk),
		.rst_pulse (rst_pulse),
		.push      (wr_ok),
		.push_data (push_entry),
		.pop       (bus.wr_pop),
		.head      (head),
		.empty     (fifo_empty),
		.full      (fifo_full)
	);

	always_ff @(posedge clk) begin
		if (rd_ok) begin
			line_tag <= addr_tag;
			rd_word  <= addr[LANE_W +: LINE_IDX_W];
			rd_lane  <= addr[LANE_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			line_dirty <= 1'b1;
			hit_busy   <= 1'b0;
			rd_miss    <= 1'b0;
		end else begin
			hit_busy <= rd_ok && hit;
			if (rd_ok) begin
				line_dirty <= 1'b0;
				rd_miss    <= !hit;
			end else if (bus.fill_done) begin
				rd_miss <= 1'b0;
			end
			// the queued write lands before the next refill, so refetch
			if (wr_ok && (addr_tag == line_tag)) begin
				line_dirty <= 1'b1;
			end
		end
	end

	// lane 0 is the most significant halfword
	assign wr_lane       = head.addr[LANE_W-1:0];
	assign bus.wr_valid  = !fifo_empty;
	assign bus.wr_addr   = REGION_BASE + ddr_addr_t'(head.addr[CLIENT_AW-1:LANE_W]);
	assign bus.wr_data   = {LANES{head.data}};
	assign bus.wr_be     = ddr_be_t'({head.be, {(DDR_BEW-CLIENT_BEW){1'b0}}}) >> {wr_lane, 1'b0};
	assign bus.rd_miss   = rd_miss;
	assign bus.line_addr = REGION_BASE + ddr_addr_t'({line_tag, {LINE_IDX_W{1'b0}}});

	line_cache i_line_cache (
		.clk     (clk),
		.wr_en   (bus.fill_en),
		.wr_idx  (bus.fill_idx),
		.wr_data (bus.fill_data),
		.rd_idx  (rd_word),
		.rd_data (line_word)
	);

	assign dout = line_word[(LANES - 1 - int'(rd_lane)) * CLIENT_DW +: CLIENT_DW];

endmodule

`default_nettype wire

//--- src/burst_counter.sv
// refill beat counter
// gives the line buffer write index and flags the last beat of a line
`timescale 1ns/1ns
`default_nettype none

module burst_counter import ddram_pkg::*; (
	input  logic      clk,
	input  logic      rst_pulse,
	input  logic      start,
	input  logic      beat_en,
	output line_idx_t beat_idx,
	output logic      beat_last
);

	always_ff @(posedge clk) begin
		if (rst_pulse || start) begin
			beat_idx <= '0;
		end else if (beat_en) begin
			beat_idx <= beat_idx + 1'b1;
		end
	end

	assign beat_last = beat_en && (beat_idx == line_idx_t'(LINE_WORDS - 1));

endmodule

`default_nettype wire

//--- src/ddr_sched_fsm.sv
// fixed-priority DDR scheduler
// order is client 0 write, client 0 refill, client 1 write, client 1 refill
// issues single-beat masked writes and line-sized burst reads
`timescale 1ns/1ns
`default_nettype none

module ddr_sched_fsm import ddram_pkg::*; (
	input  logic               clk,
	input  logic               rst_pulse,
	client_if.sched            c0,
	client_if.sched            c1,
	input  logic               ddram_busy,
	input  ddr_data_t          ddram_dout,
	input  logic               ddram_dout_ready,
	input  line_idx_t          beat_idx,
	input  logic               beat_last,
	output logic               beat_en,
	output logic [BURST_W-1:0] ddram_burstcnt,
	output ddr_addr_t          ddram_addr,
	output logic               ddram_rd,
	output ddr_data_t          ddram_din,
	output ddr_be_t            ddram_be,
	output logic               ddram_we
);

	sched_state_t state;
	logic         cmd_owner;
	logic         fill_done0;
	logic         fill_done1;
	logic         c0_fill_req;
	logic         c1_fill_req;
	logic         issue_ok;
	logic         sel_write;
	logic         sel_read;
	logic         sel_owner;

	// rd_miss is still high in the fill_done cycle, so mask it there
	assign c0_fill_req = c0.rd_miss && !fill_done0;
	assign c1_fill_req = c1.rd_miss && !fill_done1;
	assign issue_ok    = (state == ST_IDLE) && !ddram_busy;

	always_comb begin
		sel_write = 1'b0;
		sel_read  = 1'b0;
		sel_owner = 1'b0;
		if (c0.wr_valid) begin
			sel_write = 1'b1;
		end else if (c0_fill_req) begin
			sel_read = 1'b1;
		end else if (c1.wr_valid) begin
			sel_write = 1'b1;
			sel_owner = 1'b1;
		end else if (c1_fill_req) begin
			sel_read  = 1'b1;
			sel_owner = 1'b1;
		end
	end

	assign c0.wr_pop = issue_ok && sel_write && !sel_owner;
	assign c1.wr_pop = issue_ok && sel_write && sel_owner;

	// read beats are taken whenever they show up, independent of busy
	assign beat_en      = (state == ST_READ) && ddram_dout_ready;
	assign c0.fill_en   = beat_en && !cmd_owner;
	assign c1.fill_en   = beat_en && cmd_owner;
	assign c0.fill_idx  = beat_idx;
	assign c1.fill_idx  = beat_idx;
	assign c0.fill_data = ddram_dout;
	assign c1.fill_data = ddram_dout;
	assign c0.fill_done = fill_done0;
	assign c1.fill_done = fill_done1;

	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			state    <= ST_IDLE;
			ddram_rd <= 1'b0;
			ddram_we <= 1'b0;
		end else begin
			// a held command drops on the first edge with busy low
			if (!ddram_busy) begin
				ddram_rd <= 1'b0;
				ddram_we <= 1'b0;
			end
			case (state)
				ST_IDLE: if (issue_ok) begin
					if (sel_write) begin
						ddram_we <= 1'b1;
						state    <= ST_WRITE;
					end else if (sel_read) begin
						ddram_rd <= 1'b1;
						state    <= ST_READ;
					end
				end
				ST_WRITE: if (!ddram_busy) begin
					state <= ST_IDLE;
				end
				ST_READ: if (beat_last) begin
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			fill_done0 <= 1'b0;
			fill_done1 <= 1'b0;
		end else begin
			fill_done0 <= beat_last && !cmd_owner;
			fill_done1 <= beat_last && cmd_owner;
		end
	end

	// command payload, captured at issue
	always_ff @(posedge clk) begin
		if (issue_ok && (sel_write || sel_read)) begin
			cmd_owner <= sel_owner;
			if (sel_write) begin
				ddram_addr     <= sel_owner ? c1.wr_addr : c0.wr_addr;
				ddram_din      <= sel_owner ? c1.wr_data : c0.wr_data;
				ddram_be       <= sel_owner ? c1.wr_be : c0.wr_be;
				ddram_burstcnt <= BURST_W'(1);
			end else begin
				ddram_addr     <= sel_owner ? c1.line_addr : c0.line_addr;
				ddram_be       <= '1;
				ddram_burstcnt <= BURST_W'(LINE_WORDS);
			end
		end
	end

endmodule

`default_nettype wire

//--- src/ddram_ctrl.sv
// DDR3 front-end top level
// two 16-bit clients, each with a one-line read cache and a posted write queue,
// share one 64-bit burst port through a fixed-priority scheduler
`timescale 1ns/1ns
`default_nettype none

module ddram_ctrl import ddram_pkg::*; #(
	parameter ddr_addr_t C0_BASE      = 29'h0600_0000,
	parameter ddr_addr_t C1_BASE      = 29'h0610_0000,
	parameter int        C0_FIFO_LOG2 = 3,
	parameter int        C1_FIFO_LOG2 = 2
) (
	input  logic               clk,
	input  logic               rst_pulse,

	input  client_addr_t       c0_addr,
	input  client_data_t       c0_din,
	input  logic               c0_rd,
	input  hw_be_t             c0_wr,
	output client_data_t       c0_dout,
	output logic               c0_busy,

	input  client_addr_t       c1_addr,
	input  client_data_t       c1_din,
	input  logic               c1_rd,
	input  hw_be_t             c1_wr,
	output client_data_t       c1_dout,
	output logic               c1_busy,

	input  logic               ddram_busy,
	input  ddr_data_t          ddram_dout,
	input  logic               ddram_dout_ready,
	output logic [BURST_W-1:0] ddram_burstcnt,
	output ddr_addr_t          ddram_addr,
	output logic               ddram_rd,
	output ddr_data_t          ddram_din,
	output ddr_be_t            ddram_be,
	output logic               ddram_we
);

	client_if c0_bus ();
	client_if c1_bus ();

	logic      beat_en;
	logic      beat_last;
	line_idx_t beat_idx;

	client_port #(
		.REGION_BASE (C0_BASE),
		.FIFO_LOG2   (C0_FIFO_LOG2)
	) i_c0_port (
		.clk       (clk),
		.rst_pulse (rst_pulse),
		.addr      (c0_addr),
		.din       (c0_din),
		.rd        (c0_rd),
		.wr        (c0_wr),
		.dout      (c0_dout),
		.busy      (c0_busy),
		.bus       (c0_bus)
	);

	client_port #(
		.REGION_BASE (C1_BASE),
		.FIFO_LOG2   (C1_FIFO_LOG2)
	) i_c1_port (
		.clk       (clk),
		.rst_pulse (rst_pulse),
		.addr      (c1_addr),
		.din       (c1_din),
		.rd        (c1_rd),
		.wr        (c1_wr),
		.dout      (c1_dout),
		.busy      (c1_busy),
		.bus       (c1_bus)
	);

	ddr_sched_fsm i_sched (
		.clk              (clk),
		.rst_pulse        (rst_pulse),
		.c0               (c0_bus),
		.c1               (c1_bus),
		.ddram_busy       (ddram_busy),
		.ddram_dout       (ddram_dout),
		.ddram_dout_ready (ddram_dout_ready),
		.beat_idx         (beat_idx),
		.beat_last        (beat_last),
		.beat_en          (beat_en),
		.ddram_burstcnt   (ddram_burstcnt),
		.ddram_addr       (ddram_addr),
		.ddram_rd         (ddram_rd),
		.ddram_din        (ddram_din),
		.ddram_be         (ddram_be),
		.ddram_we         (ddram_we)
	);

	// counter stays cleared while the burst read command is pending
	burst_counter i_burst_counter (
		.clk       (clk),
		.rst_pulse (rst_pulse),
		.start     (ddram_rd),
		.beat_en   (beat_en),
		.beat_idx  (beat_idx),
		.beat_last (beat_last)
	);

endmodule

`default_nettype wire

//--- sim/ddram_model.sv
// behavioral DDR memory for the testbench
// byte-masked writes, random busy stalls and burst reads with random beat gaps
`timescale 1ns/1ns
`default_nettype none

module ddram_model import ddram_pkg::*; #(
	parameter int SEED = 32'h8afc
) (
	input  logic               clk,
	input  logic               hold_busy,
	input  logic [BURST_W-1:0] burstcnt,
	input  ddr_addr_t          addr,
	input  logic               rd,
	input  ddr_data_t          din,
	input  ddr_be_t            be,
	input  logic               we,
	output logic               busy,
	output ddr_data_t          dout,
	output logic               dout_ready,
	output int                 rd_count,
	output int                 last_burstcnt,
	output ddr_addr_t          last_rd_addr
);

	ddr_data_t mem [ddr_addr_t];
	integer    seed;
	logic      hold_q;
	logic      stall;
	int        beats_left;
	ddr_addr_t beat_addr;

	// unwritten words read back as a pattern of their own address
	function automatic ddr_data_t fill_word(input ddr_addr_t a);
		return {a, ~a, 6'h15};
	endfunction

	function automatic ddr_data_t peek(input ddr_addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return fill_word(a);
	endfunction

	function automatic ddr_data_t merge(input ddr_data_t old, input ddr_data_t nw,
		input ddr_be_t mask);
		ddr_data_t r;
		r = old;
		for (int i = 0; i < DDR_BEW; i++) begin
			if (mask[i]) begin
				r[i*8 +: 8] = nw[i*8 +: 8];
			end
		end
		return r;
	endfunction

	initial begin
		seed          = SEED;
		hold_q        = 1'b0;
		stall         = 1'b0;
		beats_left    = 0;
		beat_addr     = '0;
		busy          = 1'b0;
		dout          = '0;
		dout_ready    = 1'b0;
		rd_count      = 0;
		last_burstcnt = 0;
		last_rd_addr  = '0;
	end

	always @(posedge clk) begin
		hold_q <= hold_busy;
	end

	always @(negedge clk) begin
		stall = hold_q || (($random(seed) & 3) == 0);
		// pending beats first, so a new burst starts after its accepting edge
		if (beats_left > 0 && ($random(seed) & 1) == 1) begin
			dout       <= peek(beat_addr);
			dout_ready <= 1'b1;
			beat_addr  = beat_addr + 1'b1;
			beats_left = beats_left - 1;
		end else begin
			dout_ready <= 1'b0;
		end
		// a command is taken at the next rising edge unless stalled
		if (we === 1'b1 && !stall) begin
			mem[addr] = merge(peek(addr), din, be);
		end
		if (rd === 1'b1 && !stall) begin
			rd_count      <= rd_count + 1;
			last_burstcnt <= int'(burstcnt);
			last_rd_addr  <= addr;
			beat_addr     = addr;
			beats_left    = int'(burstcnt);
		end
		busy <= stall;
	end

endmodule

`default_nettype wire

//--- sim/tb_ddram_ctrl.sv
// testbench for the DDR3 front-end
// directed tests for posted writes, read hits and misses, line invalidation,
// region separation and write queue back-pressure
`timescale 1ns/1ns
`default_nettype none

module tb_ddram_ctrl import ddram_pkg::*; ();

	localparam ddr_addr_t    C0_BASE      = 29'h0600_0000;
	localparam ddr_addr_t    C1_BASE      = 29'h0610_0000;
	localparam int           C0_FIFO_LOG2 = 3;
	localparam int           C1_FIFO_LOG2 = 2;
	localparam int           HALF_PERIOD  = 4;
	localparam client_addr_t LINE_A       = 18'h00120;
	// worst case of one client operation with stalls and beat gaps
	localparam int           OP_CYCLES    = 40;
	localparam int           TEST_OPS     = 8 + 3 + 2 + 4 + 2 * (1 << C1_FIFO_LOG2);
	localparam int           TIMEOUT_CYCLES = 4 * (8 + TEST_OPS * OP_CYCLES);

	logic               clk;
	logic               rst_pulse;
	client_addr_t       c0_addr;
	client_data_t       c0_din;
	logic               c0_rd;
	hw_be_t             c0_wr;
	client_data_t       c0_dout;
	logic               c0_busy;
	client_addr_t       c1_addr;
	client_data_t       c1_din;
	logic               c1_rd;
	hw_be_t             c1_wr;
	client_data_t       c1_dout;
	logic               c1_busy;
	logic               ddram_busy;
	ddr_data_t          ddram_dout;
	logic               ddram_dout_ready;
	logic [BURST_W-1:0] ddram_burstcnt;
	ddr_addr_t          ddram_addr;
	logic               ddram_rd;
	ddr_data_t          ddram_din;
	ddr_be_t            ddram_be;
	logic               ddram_we;
	logic               hold_busy;
	int                 rd_count;
	int                 last_burstcnt;
	ddr_addr_t          last_rd_addr;
	int                 cycles = 0;
	int                 data_errs = 0;
	int                 addr_errs = 0;
	int                 count_errs = 0;

	ddram_ctrl #(
		.C0_BASE      (C0_BASE),
		.C1_BASE      (C1_BASE),
		.C0_FIFO_LOG2 (C0_FIFO_LOG2),
		.C1_FIFO_LOG2 (C1_FIFO_LOG2)
	) i_ddram_ctrl (
		.clk              (clk),
		.rst_pulse        (rst_pulse),
		.c0_addr          (c0_addr),
		.c0_din           (c0_din),
		.c0_rd            (c0_rd),
		.c0_wr            (c0_wr),
		.c0_dout          (c0_dout),
		.c0_busy          (c0_busy),
		.c1_addr          (c1_addr),
		.c1_din           (c1_din),
		.c1_rd            (c1_rd),
		.c1_wr            (c1_wr),
		.c1_dout          (c1_dout),
		.c1_busy          (c1_busy),
		.ddram_busy       (ddram_busy),
		.ddram_dout       (ddram_dout),
		.ddram_dout_ready (ddram_dout_ready),
		.ddram_burstcnt   (ddram_burstcnt),
		.ddram_addr       (ddram_addr),
		.ddram_rd         (ddram_rd),
		.ddram_din        (ddram_din),
		.ddram_be         (ddram_be),
		.ddram_we         (ddram_we)
	);

	ddram_model i_ddram_model (
		.clk           (clk),
		.hold_busy     (hold_busy),
		.burstcnt      (ddram_burstcnt),
		.addr          (ddram_addr),
		.rd            (ddram_rd),
		.din           (ddram_din),
		.be            (ddram_be),
		.we            (ddram_we),
		.busy          (ddram_busy),
		.dout          (ddram_dout),
		.dout_ready    (ddram_dout_ready),
		.rd_count      (rd_count),
		.last_burstcnt (last_burstcnt),
		.last_rd_addr  (last_rd_addr)
	);

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, scheduler in %s", cycles,
				i_ddram_ctrl.i_sched.state.name());
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_data(input string what, input client_data_t got,
		input client_data_t exp);
		if (got !== exp) begin
			data_errs++;
			$display("Error: %s got %h expected %h", what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input ddr_addr_t got, input ddr_addr_t exp);
		if (got !== exp) begin
			addr_errs++;
			$display("Error: %s got %h expected %h", what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			count_errs++;
			$display("Error: %s got %h expected %h", what, got, exp);
		end
	endtask

	function automatic client_data_t hw_value(input int salt, input client_addr_t a);
		return client_data_t'(salt * 40503) ^ a[CLIENT_DW-1:0];
	endfunction

	// lane 0 sits in the top halfword of the DDR word
	function automatic client_data_t lane_of(input ddr_data_t w, input int lane);
		return client_data_t'(w >> (CLIENT_DW * (3 - lane)));
	endfunction

	function automatic client_data_t mem_halfword(input ddr_addr_t base, input client_addr_t a);
		return lane_of(i_ddram_model.peek(base + ddr_addr_t'(a >> 2)), int'(a[1:0]));
	endfunction

	function automatic logic client_busy(input int c);
		return (c == 0) ? c0_busy : c1_busy;
	endfunction

	task automatic wait_ready(input int c);
		while (client_busy(c)) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_drained();
		while (i_ddram_ctrl.i_sched.state != ST_IDLE || ddram_we || ddram_rd
			|| i_ddram_ctrl.c0_bus.wr_valid || i_ddram_ctrl.c1_bus.wr_valid) begin
			@(negedge clk);
		end
	endtask

	task automatic client_write(input int c, input client_addr_t a, input client_data_t d);
		wait_ready(c);
		if (c == 0) begin
			c0_addr = a;
			c0_din  = d;
			c0_wr   = 2'b11;
		end else begin
			c1_addr = a;
			c1_din  = d;
			c1_wr   = 2'b11;
		end
		@(negedge clk);
		c0_wr = '0;
		c1_wr = '0;
	endtask

	// busy_cycles counts the cycles with busy high after the strobe
	task automatic client_read(input int c, input client_addr_t a,
		output client_data_t d, output int busy_cycles);
		busy_cycles = 0;
		wait_ready(c);
		if (c == 0) begin
			c0_addr = a;
			c0_rd   = 1'b1;
		end else begin
			c1_addr = a;
			c1_rd   = 1'b1;
		end
		@(negedge clk);
		c0_rd = 1'b0;
		c1_rd = 1'b0;
		while (client_busy(c)) begin
			busy_cycles++;
			@(negedge clk);
		end
		d = (c == 0) ? c0_dout : c1_dout;
	endtask

	task automatic test_reset();
		check_count("ddram_rd", int'(ddram_rd), 0);
		check_count("ddram_we", int'(ddram_we), 0);
		check_count("c0_busy", int'(c0_busy), 0);
		check_count("c1_busy", int'(c1_busy), 0);
	endtask

	task automatic test_write_read();
		client_data_t got;
		ddr_data_t    word;
		int           bc;
		int           n0;
		for (int l = 0; l < 4; l++) begin
			client_write(0, LINE_A + client_addr_t'(l), hw_value(1, LINE_A + client_addr_t'(l)));
		end
		n0 = rd_count;
		for (int l = 0; l < 4; l++) begin
			client_read(0, LINE_A + client_addr_t'(l), got, bc);
			check_data("c0_dout", got, hw_value(1, LINE_A + client_addr_t'(l)));
		end
		// the line starts dirty, so exactly one refill
		check_count("ddram_rd commands", rd_count - n0, 1);
		wait_drained();
		word = i_ddram_model.peek(C0_BASE + ddr_addr_t'(LINE_A >> 2));
		for (int l = 0; l < 4; l++) begin
			check_data("ddram word lane", lane_of(word, l),
				hw_value(1, LINE_A + client_addr_t'(l)));
		end
	endtask

	task automatic test_hit_miss();
		client_addr_t a;
		client_data_t got;
		int           bc;
		int           n0;
		n0 = rd_count;
		a  = LINE_A + 18'd4;
		client_read(0, a, got, bc);
		check_count("c0_busy cycles on hit", bc, 1);
		check_count("ddram_rd commands on hit", rd_count - n0, 0);
		check_data("c0_dout", got, mem_halfword(C0_BASE, a));
		a = LINE_A + 18'd16;
		client_read(0, a, got, bc);
		check_count("ddram_rd commands on miss", rd_count - n0, 1);
		check_count("ddram_burstcnt", last_burstcnt, LINE_WORDS);
		check_addr("ddram_addr", last_rd_addr, C0_BASE + ddr_addr_t'(a >> 2));
		check_data("c0_dout", got, mem_halfword(C0_BASE, a));
	endtask

	task automatic test_invalidate();
		client_addr_t a;
		client_data_t got;
		int           bc;
		int           n0;
		a  = LINE_A + 18'd21;
		n0 = rd_count;
		client_write(0, a, hw_value(2, a));
		client_read(0, a, got, bc);
		check_data("c0_dout", got, hw_value(2, a));
		check_count("ddram_rd commands after invalidation", rd_count - n0, 1);
	endtask

	task automatic test_two_clients();
		client_addr_t a;
		client_data_t got;
		int           bc;
		a = 18'h00200;
		client_write(0, a, hw_value(3, a));
		client_write(1, a, hw_value(4, a));
		// both writes land before either client fetches its line
		wait_drained();
		check_data("ddram c0 region lane", mem_halfword(C0_BASE, a), hw_value(3, a));
		check_data("ddram c1 region lane", mem_halfword(C1_BASE, a), hw_value(4, a));
		client_read(0, a, got, bc);
		check_data("c0_dout", got, hw_value(3, a));
		client_read(1, a, got, bc);
		check_data("c1_dout", got, hw_value(4, a));
	endtask

	task automatic test_back_pressure();
		client_addr_t a;
		client_data_t got;
		int           bc;
		int           n;
		a = 18'h00340;
		wait_drained();
		hold_busy = 1'b1;
		repeat (2) @(negedge clk);
		n = 0;
		while (!c1_busy && n < 16) begin
			c1_addr = a + client_addr_t'(n);
			c1_din  = hw_value(5, c1_addr);
			c1_wr   = 2'b11;
			@(negedge clk);
			c1_wr = '0;
			n++;
		end
		check_count("c1 writes before c1_busy", n, 1 << C1_FIFO_LOG2);
		hold_busy = 1'b0;
		for (int i = 0; i < n; i++) begin
			client_read(1, a + client_addr_t'(i), got, bc);
			check_data("c1_dout", got, hw_value(5, a + client_addr_t'(i)));
		end
	endtask

	initial begin
		rst_pulse = 1'b1;
		hold_busy = 1'b0;
		c0_addr   = '0;
		c0_din    = '0;
		c0_rd     = 1'b0;
		c0_wr     = '0;
		c1_addr   = '0;
		c1_din    = '0;
		c1_rd     = 1'b0;
		c1_wr     = '0;
		repeat (3) @(negedge clk);
		rst_pulse = 1'b0;
		@(negedge clk);
		test_reset();
		test_write_read();
		test_hit_miss();
		test_invalidate();
		test_two_clients();
		test_back_pressure();
		$display("errors: data %0d, address %0d, count %0d", data_errs, addr_errs, count_errs);
		if (data_errs + addr_errs + count_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
common/ddram_pkg.sv
common/client_if.sv
client/write_fifo.sv
client/line_cache.sv
client/client_port.sv
src/burst_counter.sv
src/ddr_sched_fsm.sv
src/ddram_ctrl.sv
sim/ddram_model.sv
sim/tb_ddram_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the ddram_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ddram_ctrl -f src.f -o tb_ddram_ctrl
./obj_dir/tb_ddram_ctrl | tee sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
